//--- rtl/csr_index_pkg.sv
`default_nettype none

package csr_index_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int INDEX_W = 32;
    localparam int ADDR_W  = 64;
    localparam int SHIFT_W = 6;

    // Request FIFO sizing
    // Threshold leaves room for the requests still in the producer pipeline
    localparam int FIFO_DEPTH  = 16;
    localparam int PROG_THRESH = 8;
    localparam int FIFO_CNT_W  = 5;

    // ----------------------------------------
    // Enums
    // ----------------------------------------
    typedef enum logic {
        COUNT_UP   = 1'b0,
        COUNT_DOWN = 1'b1
    } count_dir_e;

    // How the index turns into a byte offset
    typedef enum logic {
        SHIFT_RIGHT = 1'b0,
        SHIFT_LEFT  = 1'b1
    } shift_dir_e;

    typedef enum logic {
        SEQ_RUNNING = 1'b0,
        SEQ_DONE    = 1'b1
    } seq_state_e;

    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        START = 3'd1,
        BUSY  = 3'd2,
        PAUSE = 3'd3,
        DRAIN = 3'd4,
        DONE  = 3'd5
    } gen_state_e;

    // ----------------------------------------
    // Structs
    // ----------------------------------------
    typedef struct packed {
        logic [INDEX_W-1:0] index_start;
        logic [INDEX_W-1:0] index_end;
        logic [INDEX_W-1:0] stride;
        count_dir_e         count_dir;
        logic [ADDR_W-1:0]  array_pointer;
        shift_dir_e         shift_dir;
        logic [SHIFT_W-1:0] shift_amount;
    } index_config_t;

    typedef struct packed {
        logic [ADDR_W-1:0]  base;
        logic [ADDR_W-1:0]  offset;
        logic [INDEX_W-1:0] index;
        seq_state_e         seq_state;
    } index_request_t;

endpackage

`default_nettype wire

//--- rtl/csr_index_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module csr_index_sequencer
    import csr_index_pkg::*;
(
    input  logic           ap_clk,
    input  logic           areset_generator,
    input  logic           cfg_valid,
    input  index_config_t  cfg,
    input  logic           prog_full,
    output logic           push,
    output index_request_t push_data,
    output logic           seq_start,
    output logic           seq_finished
);

    gen_state_e    state;
    gen_state_e    state_next;
    index_config_t cfg_reg;

    logic [INDEX_W-1:0] index_q;
    logic [INDEX_W-1:0] cur_index;
    logic [INDEX_W:0]   next_wide;
    logic               next_ok;
    logic               start_ok;
    logic               issue;

    logic               s1_valid;
    logic [INDEX_W-1:0] s1_index;
    logic               s1_last;
    logic [ADDR_W-1:0]  s1_offset;
    logic               s2_valid;
    index_request_t     s2_req;

    // Index still inside the configured bound
    function automatic logic in_range(input logic [INDEX_W-1:0] idx,
                                      input logic [INDEX_W-1:0] bound,
                                      input count_dir_e dir);
        if (dir == COUNT_UP) begin
            return idx < bound;
        end
        return idx > bound;
    endfunction

    assign seq_start    = (state == IDLE) && cfg_valid;
    assign seq_finished = (state == DONE);

    // ----------------------------------------
    // Index counter
    // ----------------------------------------
    // START issues the start index straight from the captured config
    assign cur_index = (state == START) ? cfg_reg.index_start : index_q;
    assign start_ok  = in_range(cfg_reg.index_start, cfg_reg.index_end, cfg_reg.count_dir);

    // Extra bit catches wrap past either end of the index range
    assign next_wide = (cfg_reg.count_dir == COUNT_UP) ?
                       {1'b0, cur_index} + {1'b0, cfg_reg.stride} :
                       {1'b0, cur_index} - {1'b0, cfg_reg.stride};
    assign next_ok   = !next_wide[INDEX_W] &&
                       in_range(next_wide[INDEX_W-1:0], cfg_reg.index_end, cfg_reg.count_dir);

    always_ff @(posedge ap_clk) begin
        if (seq_start) begin
            cfg_reg <= cfg;
        end
        if (issue) begin
            index_q <= next_wide[INDEX_W-1:0];
        end
    end

    // ----------------------------------------
    // FSM
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        issue      = 1'b0;
        case (state)
            IDLE: begin
                if (cfg_valid) begin
                    state_next = START;
                end
            end
            START: begin
                issue = start_ok;
                if (start_ok && next_ok) begin
                    state_next = BUSY;
                end else begin
                    state_next = DRAIN;
                end
            end
            BUSY: begin
                issue = 1'b1;
                if (!next_ok) begin
                    state_next = DRAIN;
                end else if (prog_full) begin
                    state_next = PAUSE;
                end
            end
            PAUSE: begin
                if (!prog_full) begin
                    state_next = BUSY;
                end
            end
            // Wait for the last request to leave the pipeline
            DRAIN: begin
                if (!s1_valid && !s2_valid) begin
                    state_next = DONE;
                end
            end
            DONE: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // ----------------------------------------
    // Request pipeline
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= issue;
            s2_valid <= s1_valid;
        end
    end

    assign s1_offset = (cfg_reg.shift_dir == SHIFT_LEFT) ?
                       ADDR_W'(s1_index) << cfg_reg.shift_amount :
                       ADDR_W'(s1_index) >> cfg_reg.shift_amount;

    always_ff @(posedge ap_clk) begin
        s1_index         <= cur_index;
        s1_last          <= !next_ok;
        s2_req.base      <= cfg_reg.array_pointer;
        s2_req.offset    <= s1_offset;
        s2_req.index     <= s1_index;
        s2_req.seq_state <= s1_last ? SEQ_DONE : SEQ_RUNNING;
    end

    assign push      = s2_valid;
    assign push_data = s2_req;

endmodule

`default_nettype wire

//--- rtl/request_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module request_fifo
    import csr_index_pkg::*;
(
    input  logic           ap_clk,
    input  logic           areset_generator,
    input  logic           push,
    input  index_request_t push_data,
    input  logic           pop,
    output index_request_t pop_data,
    output logic           empty,
    output logic           prog_full
);

    index_request_t mem [FIFO_DEPTH];

    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0]         count;
    logic                          full;
    logic                          wr_ok;
    logic                          rd_ok;

    assign full  = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign wr_ok = push && !full;
    assign rd_ok = pop && !empty;

    // Storage
    always_ff @(posedge ap_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign pop_data = mem[rd_ptr];

    // ----------------------------------------
    // Pointers and occupancy
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign empty     = (count == '0);
    assign prog_full = (count >= FIFO_CNT_W'(PROG_THRESH));

endmodule

`default_nettype wire

//--- rtl/request_issue.sv
`timescale 1ns/1ps
`default_nettype none

module request_issue
    import csr_index_pkg::*;
(
    input  logic           ap_clk,
    input  logic           areset_generator,
    input  logic           request_rd_en,
    input  logic           empty,
    input  index_request_t pop_data,
    input  logic           seq_start,
    input  logic           seq_finished,
    output logic           pop,
    output logic           request_valid,
    output index_request_t request,
    output logic           done
);

    logic finish_pending;

    // Downstream read-enable gates every pop
    assign pop = request_rd_en && !empty;

    // ----------------------------------------
    // Output register
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            request_valid <= 1'b0;
        end else begin
            request_valid <= pop;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (pop) begin
            request <= pop_data;
        end
    end

    // ----------------------------------------
    // Completion
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            finish_pending <= 1'b0;
            done           <= 1'b0;
        end else if (seq_start) begin
            finish_pending <= 1'b0;
            done           <= 1'b0;
        end else begin
            if (seq_finished) begin
                finish_pending <= 1'b1;
            end
            // Producer idle, FIFO drained, last beat already out
            done <= finish_pending && empty && !request_valid;
        end
    end

endmodule

`default_nettype wire

//--- rtl/csr_index_generator.sv
`timescale 1ns/1ps
`default_nettype none

module csr_index_generator
    import csr_index_pkg::*;
(
    input  logic           ap_clk,
    input  logic           areset_generator,
    input  logic           cfg_valid,
    input  index_config_t  cfg,
    input  logic           request_rd_en,
    output logic           request_valid,
    output index_request_t request,
    output logic           done
);

    logic           push;
    index_request_t push_data;
    logic           prog_full;
    logic           pop;
    index_request_t pop_data;
    logic           empty;
    logic           seq_start;
    logic           seq_finished;

    // Producer
    csr_index_sequencer u_csr_index_sequencer (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .cfg_valid        (cfg_valid),
        .cfg              (cfg),
        .prog_full        (prog_full),
        .push             (push),
        .push_data        (push_data),
        .seq_start        (seq_start),
        .seq_finished     (seq_finished)
    );

    request_fifo u_request_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (push),
        .push_data        (push_data),
        .pop              (pop),
        .pop_data         (pop_data),
        .empty            (empty),
        .prog_full        (prog_full)
    );

    // Consumer
    request_issue u_request_issue (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .request_rd_en    (request_rd_en),
        .empty            (empty),
        .pop_data         (pop_data),
        .seq_start        (seq_start),
        .seq_finished     (seq_finished),
        .pop              (pop),
        .request_valid    (request_valid),
        .request          (request),
        .done             (done)
    );

endmodule

`default_nettype wire

//--- test/csr_index_generator_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csr_index_generator_tb
    import csr_index_pkg::*;
();

    localparam int DONE_TIMEOUT = 3000;
    localparam int MAX_MODEL    = 4096;

    logic           ap_clk;
    logic           areset_generator;
    logic           cfg_valid;
    index_config_t  cfg;
    logic           request_rd_en;
    logic           request_valid;
    index_request_t request;
    logic           done;

    index_request_t exp_q[$];
    index_request_t exp_req;
    string          test_name;
    int             errors;
    int             tests;
    int             rx_count;
    int             hold_low;
    logic           rd_random;

    csr_index_generator u_csr_index_generator (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .cfg_valid        (cfg_valid),
        .cfg              (cfg),
        .request_rd_en    (request_rd_en),
        .request_valid    (request_valid),
        .request          (request),
        .done             (done)
    );

    always #10 ap_clk = ~ap_clk;

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic logic ahead_of_end(input logic [INDEX_W-1:0] idx,
                                          input index_config_t c);
        if (c.count_dir == COUNT_UP) begin
            return idx < c.index_end;
        end
        return idx > c.index_end;
    endfunction

    task automatic load_model(input index_config_t c);
        logic [INDEX_W:0]  idx;
        logic [ADDR_W-1:0] wide;
        index_request_t    r;
        exp_q.delete();
        idx = {1'b0, c.index_start};
        while (!idx[INDEX_W] && ahead_of_end(idx[INDEX_W-1:0], c) &&
               exp_q.size() < MAX_MODEL) begin
            wide                 = '0;
            wide[INDEX_W-1:0]    = idx[INDEX_W-1:0];
            r.base               = c.array_pointer;
            r.index              = idx[INDEX_W-1:0];
            r.offset             = (c.shift_dir == SHIFT_LEFT) ? (wide << c.shift_amount) :
                                                                 (wide >> c.shift_amount);
            r.seq_state          = SEQ_RUNNING;
            exp_q.push_back(r);
            if (c.count_dir == COUNT_UP) begin
                idx = {1'b0, idx[INDEX_W-1:0]} + {1'b0, c.stride};
            end else begin
                idx = {1'b0, idx[INDEX_W-1:0]} - {1'b0, c.stride};
            end
        end
        // Only the final request carries the done marker
        if (exp_q.size() > 0) begin
            r           = exp_q.pop_back();
            r.seq_state = SEQ_DONE;
            exp_q.push_back(r);
        end
    endtask

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    always @(negedge ap_clk) begin
        if (!areset_generator && request_valid) begin
            rx_count++;
            if (exp_q.size() == 0) begin
                $display("unexpected request with index %0d in test %s", request.index, test_name);
                errors++;
            end else begin
                exp_req = exp_q.pop_front();
                assert (request == exp_req) else begin
                    $display("mismatch %s expected %h actual %h", test_name, exp_req, request);
                    errors++;
                end
            end
        end
    end

    done_low_while_issuing: assert property (@(negedge ap_clk) disable iff (areset_generator)
        request_valid |-> !done) else begin
        $display("done was high during a request beat in test %s", test_name);
        errors++;
    end

    done_holds_until_cfg: assert property (@(negedge ap_clk) disable iff (areset_generator)
        done && !cfg_valid |=> done) else begin
        $display("done dropped without a new configuration in test %s", test_name);
        errors++;
    end

    done_drops_on_cfg: assert property (@(negedge ap_clk) disable iff (areset_generator)
        cfg_valid && done |=> !done) else begin
        $display("done stayed high after cfg_valid in test %s", test_name);
        errors++;
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    // One cycle with read-enable set by the current mode
    task automatic tick();
        @(posedge ap_clk);
        #1;
        if (hold_low > 0) begin
            request_rd_en = 1'b0;
            hold_low--;
        end else if (rd_random) begin
            request_rd_en = ($urandom % 2) == 1;
        end else begin
            request_rd_en = 1'b1;
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (done !== 1'b1) begin
            tick();
            n++;
            if (n > DONE_TIMEOUT) begin
                $display("timeout waiting for done in test %s", test_name);
                $display("TEST RESULT: FAIL");
                $finish;
            end
        end
    endtask

    task automatic run_test(input string name, input index_config_t c,
                            input int low_cycles, input logic random_rd, input int idle_after);
        int expected_n;
        int err_before;
        test_name  = name;
        err_before = errors;
        load_model(c);
        expected_n = exp_q.size();
        rx_count   = 0;
        hold_low   = low_cycles;
        rd_random  = random_rd;
        tick();
        cfg_valid = 1'b1;
        cfg       = c;
        tick();
        cfg_valid = 1'b0;
        wait_done();
        repeat (idle_after) tick();
        assert (rx_count == expected_n) else begin
            $display("mismatch %s count expected %0d actual %0d", name, expected_n, rx_count);
            errors++;
        end
        rd_random = 1'b0;
        tests++;
        $display("test %s finished with %0d requests and %0d errors",
                 name, rx_count, errors - err_before);
    endtask

    function automatic index_config_t make_cfg(input int start, input int stop, input int step,
                                               input count_dir_e cdir, input logic [63:0] ptr,
                                               input shift_dir_e sdir, input int amt);
        index_config_t c;
        c.index_start   = INDEX_W'(start);
        c.index_end     = INDEX_W'(stop);
        c.stride        = INDEX_W'(step);
        c.count_dir     = cdir;
        c.array_pointer = ptr;
        c.shift_dir     = sdir;
        c.shift_amount  = SHIFT_W'(amt);
        return c;
    endfunction

    initial begin
        ap_clk           = 1'b0;
        areset_generator = 1'b1;
        cfg_valid        = 1'b0;
        cfg              = '0;
        request_rd_en    = 1'b0;
        errors           = 0;
        tests            = 0;
        rx_count         = 0;
        hold_low         = 0;
        rd_random        = 1'b0;
        test_name        = "reset";
        void'($urandom(32'h49e076f9));
        repeat (10) @(posedge ap_clk);
        #1;
        areset_generator = 1'b0;

        run_test("count_up", make_cfg(5, 25, 1, COUNT_UP, 64'h0000_1000_0000_0000,
                 SHIFT_LEFT, 3), 0, 1'b0, 4);
        run_test("count_down", make_cfg(100, 10, 3, COUNT_DOWN, 64'h0000_0000_8000_0000,
                 SHIFT_RIGHT, 1), 0, 1'b0, 4);
        // Long stall fills the FIFO past the threshold
        run_test("back_pressure", make_cfg(0, 120, 4, COUNT_UP, {$urandom, $urandom},
                 SHIFT_LEFT, 2), 30, 1'b1, 4);
        run_test("marker_done", make_cfg(7, 50, 5, COUNT_UP, 64'h0000_0000_0004_0000,
                 SHIFT_LEFT, 4), 0, 1'b0, 20);
        run_test("empty_range", make_cfg(40, 40, 2, COUNT_UP, 64'h0000_0000_0000_1000,
                 SHIFT_LEFT, 0), 0, 1'b0, 10);

        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
rtl/csr_index_pkg.sv
rtl/csr_index_sequencer.sv
rtl/request_fifo.sv
rtl/request_issue.sv
rtl/csr_index_generator.sv
test/csr_index_generator_tb.sv

//--- Makefile
TOP = csr_index_generator_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -f tb.f -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; \
		echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
